// File: mem_engine_top.f
+incdir+src
src/mem_engine_pkg.sv
src/range_counter.sv
src/block_ram.sv
src/mem_task_ctrl.sv
src/mem_engine_top.sv
sim/tb_clock_gen.sv
sim/tb_mem_checker.sv
sim/tb_mem_engine.sv

// File: sim/tb_mem_engine.sv
`timescale 1ns/1ps

`include "mem_engine_consts.svh"

module tb_mem_engine;

  import mem_engine_pkg::*;

  // random tasks stay in the top 256 words, last address included
  localparam addr_t win_base = 16'hff00;

  logic      clk;
  logic      arst_n;
  mem_task_t task_in;
  word_t     data_write;
  logic      data_write_ready;
  word_t     data_read;
  logic      data_read_valid;
  logic      task_finished;
  int        errors;

  logic [31:0] lcg_state = 32'h8f9199d4;
  bit          hung = 1'b0;
  int          passed = 0;
  int          failed = 0;
  int          t;
  int          err_before;

  tb_clock_gen i_clk_gen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  mem_engine_top i_dut (
    .clk_i              (clk),
    .arst_n_i           (arst_n),
    .task_i             (task_in),
    .data_write_i       (data_write),
    .data_write_ready_o (data_write_ready),
    .data_read_o        (data_read),
    .data_read_valid_o  (data_read_valid),
    .task_finished_o    (task_finished)
  );

  tb_mem_checker i_checker (
    .clk_i              (clk),
    .arst_n_i           (arst_n),
    .task_i             (task_in),
    .data_write_i       (data_write),
    .data_write_ready_i (data_write_ready),
    .data_read_i        (data_read),
    .data_read_valid_i  (data_read_valid),
    .task_finished_i    (task_finished),
    .errors_o           (errors)
  );

  // LCG step, upper half is the better mixed part
  function automatic word_t next_word();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];
  endfunction

  // fill value built from every address bit
  function automatic word_t fill_word(input addr_t a);
    return {a[7:0], a[15:8]} ^ 16'h5ac3;
  endfunction

  function automatic string test_name(input int idx);
    case (idx)
      0: return "idle_after_reset";
      1: return "fill_window";
      2: return "write_then_read";
      3: return "random_tasks";
      default: return "ignored_commands";
    endcase
  endfunction

  // one task, a word on every falling edge, then wait for finished
  task automatic run_task(input cmd_t cmd, input addr_t start, input int len,
                          input bit fill, input bit intrude);
    mem_task_t idle_req;
    int        beat;
    int        n;
    bit        seen;
    idle_req = '0;
    beat     = 0;
    seen     = 1'b0;
    @(negedge clk);
    task_in.cmd        = cmd;
    task_in.start_addr = start;
    task_in.end_addr   = start + addr_t'(len - 1);
    for (n = 0; (n < len + 16) && !seen; n++)
    begin
      @(negedge clk);
      task_in = idle_req;
      // second command while busy, must be dropped
      if (intrude && (n == (len - 1) / 2))
      begin
        task_in.cmd      = `MEM_CMD_WRITE;
        task_in.end_addr = 16'h0fff;
      end
      if (fill && data_write_ready)
      begin
        data_write = fill_word(start + addr_t'(beat));
        beat++;
      end
      else
        data_write = next_word();
      @(posedge clk);
      seen = task_finished;
    end
    if (!seen)
    begin
      $display("timeout: no task_finished_o within %0d cycles of the command", len + 16);
      hung = 1'b1;
    end
  endtask

  task automatic write_then_read();
    run_task(`MEM_CMD_WRITE, win_base + 16'h0020, 24, 1'b0, 1'b0);
    if (!hung)
      run_task(`MEM_CMD_READ, win_base + 16'h0020, 24, 1'b0, 1'b0);
  endtask

  task automatic random_tasks();
    int    i;
    int    len;
    addr_t start;
    cmd_t  cmd;
    for (i = 0; (i < 40) && !hung; i++)
    begin
      // every eighth task is a single word
      len   = (i % 8 == 0) ? 1 : 1 + (next_word() % 64);
      start = win_base + addr_t'(next_word() % (257 - len));
      cmd   = (next_word() > 16'h7fff) ? `MEM_CMD_READ : `MEM_CMD_WRITE;
      run_task(cmd, start, len, 1'b0, 1'b0);
    end
  endtask

  task automatic ignored_commands();
    run_task(`MEM_CMD_WRITE, win_base + 16'h0040, 16, 1'b0, 1'b1);
    if (!hung)
      run_task(`MEM_CMD_READ, win_base + 16'h0040, 16, 1'b0, 1'b1);
  endtask

  initial
  begin
    int n;
    task_in    = '0;
    data_write = '0;
    for (n = 0; (n < 40) && (arst_n !== 1'b1); n++)
      @(negedge clk);
    if (arst_n !== 1'b1)
    begin
      $display("reset was never released");
      hung = 1'b1;
    end
    for (t = 0; (t < 5) && !hung; t++)
    begin
      err_before = errors;
      case (t)
        0: repeat (10) @(negedge clk);
        1: run_task(`MEM_CMD_WRITE, win_base, 256, 1'b1, 1'b0);
        2: write_then_read();
        3: random_tasks();
        default: ignored_commands();
      endcase
      // quiet cycles so late or stray pulses still reach the checker
      repeat (4) @(negedge clk);
      if (!hung && (errors == err_before))
      begin
        passed++;
        $display("test %0d %s passed", t, test_name(t));
      end
      else
      begin
        failed++;
        $display("test %0d %s failed, %0d errors", t, test_name(t), errors - err_before);
      end
    end
    $display("tests passed %0d, failed %0d, check errors %0d", passed, failed, errors);
    if (!hung && (failed == 0) && (errors == 0))
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

// File: sim/tb_mem_checker.sv
`timescale 1ns/1ps

`include "mem_engine_consts.svh"

module tb_mem_checker (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  mem_engine_pkg::mem_task_t task_i,
  input  mem_engine_pkg::word_t     data_write_i,
  input  logic                      data_write_ready_i,
  input  mem_engine_pkg::word_t     data_read_i,
  input  logic                      data_read_valid_i,
  input  logic                      task_finished_i,
  output int                        errors_o
);

  import mem_engine_pkg::*;

  // reference memory, filled only on expected write beats
  word_t  ref_mem [`MEM_DEPTH];
  bit     written [`MEM_DEPTH];
  // rising edges since reset, edge of command acceptance is edge 0 of a task
  longint edge_no = 0;
  // edge window of the current task's beats
  longint beat_from = 0;
  longint beat_to = -1;
  // first edge where a new command is taken
  longint open_from = 0;
  bit     task_rd = 1'b0;
  addr_t  task_start = '0;
  // edges where a finished pulse is due
  longint fin_due [$];

  initial
    errors_o = 0;

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("CHECK FAILED at %0t ns: %s expected %0b, got %0b", $time, name, exp, act);
      errors_o++;
    end
  endtask

  // all DUT outputs settle via NBAs, so the edge sees the previous cycle
  always @(posedge clk_i or negedge arst_n_i)
  begin : watch
    logic   exp_ready;
    logic   exp_valid;
    logic   exp_fin;
    addr_t  a;
    longint len;
    if (!arst_n_i)
    begin
      edge_no   = 0;
      beat_from = 0;
      beat_to   = -1;
      open_from = 0;
      fin_due.delete();
    end
    else
    begin
      edge_no++;
      exp_ready = !task_rd && (edge_no >= beat_from) && (edge_no <= beat_to);
      exp_valid = task_rd && (edge_no >= beat_from) && (edge_no <= beat_to);
      exp_fin   = (fin_due.size() > 0) && (fin_due[0] == edge_no);
      check_bit("data_write_ready_o", exp_ready, data_write_ready_i);
      check_bit("data_read_valid_o", exp_valid, data_read_valid_i);
      check_bit("task_finished_o", exp_fin, task_finished_i);
      if (exp_fin)
        void'(fin_due.pop_front());
      a = task_start + addr_t'(edge_no - beat_from);
      // write beat lands in the model
      if (exp_ready)
      begin
        ref_mem[a] = data_write_i;
        written[a] = 1'b1;
      end
      if (exp_valid && !written[a])
      begin
        $display("read beat at %0t ns hit address %h that was never written", $time, a);
        errors_o++;
      end
      else if (exp_valid && (data_read_i !== ref_mem[a]))
      begin
        $display("CHECK FAILED at %0t ns: data_read_o expected %h, got %h",
                 $time, ref_mem[a], data_read_i);
        errors_o++;
      end
      // command taken only when the model says the engine is free
      if ((edge_no >= open_from) &&
          ((task_i.cmd == `MEM_CMD_WRITE) || (task_i.cmd == `MEM_CMD_READ)))
      begin
        task_rd    = (task_i.cmd == `MEM_CMD_READ);
        task_start = task_i.start_addr;
        len        = longint'(task_i.end_addr) - longint'(task_i.start_addr) + 1;
        // writes beat right away, reads after two RAM and output stages
        beat_from  = edge_no + (task_rd ? 3 : 1);
        beat_to    = beat_from + len - 1;
        fin_due.push_back(edge_no + len + (task_rd ? 3 : 1));
        open_from  = edge_no + len + (task_rd ? 2 : 1);
      end
    end
  end

endmodule

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic arst_n_o
);

  // 4 ns period
  initial
  begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // reset held for 8 cycles, released on a falling edge
  initial
  begin
    arst_n_o = 1'b0;
    repeat (8) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

// File: src/mem_engine_top.sv
`timescale 1ns/1ps

module mem_engine_top (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  mem_engine_pkg::mem_task_t task_i,
  input  mem_engine_pkg::word_t     data_write_i,
  output logic                      data_write_ready_o,
  output mem_engine_pkg::word_t     data_read_o,
  output logic                      data_read_valid_o,
  output logic                      task_finished_o
);

  import mem_engine_pkg::*;

  // controller to counter
  range_ctl_t range_ctl;
  addr_t      ctr_addr;
  logic       ctr_last;

  // controller to RAM
  ram_req_t   ram_req;
  word_t      ram_rdata;

  mem_task_ctrl i_ctrl (
    .clk_i              (clk_i),
    .arst_n_i           (arst_n_i),
    .task_i             (task_i),
    .data_write_i       (data_write_i),
    .ctr_addr_i         (ctr_addr),
    .ctr_last_i         (ctr_last),
    .ram_rdata_i        (ram_rdata),
    .range_ctl_o        (range_ctl),
    .ram_req_o          (ram_req),
    .data_write_ready_o (data_write_ready_o),
    .data_read_o        (data_read_o),
    .data_read_valid_o  (data_read_valid_o),
    .task_finished_o    (task_finished_o)
  );

  // end address captured by the counter with the load strobe
  range_counter i_counter (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .ctl_i      (range_ctl),
    .end_addr_i (task_i.end_addr),
    .count_o    (ctr_addr),
    .last_o     (ctr_last)
  );

  block_ram i_ram (
    .clk_i   (clk_i),
    .req_i   (ram_req),
    .rdata_o (ram_rdata)
  );

endmodule

// File: src/mem_task_ctrl.sv
`timescale 1ns/1ps

`include "mem_engine_consts.svh"

module mem_task_ctrl (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  mem_engine_pkg::mem_task_t  task_i,
  input  mem_engine_pkg::word_t      data_write_i,
  input  mem_engine_pkg::addr_t      ctr_addr_i,
  input  logic                       ctr_last_i,
  input  mem_engine_pkg::word_t      ram_rdata_i,
  output mem_engine_pkg::range_ctl_t range_ctl_o,
  output mem_engine_pkg::ram_req_t   ram_req_o,
  output logic                       data_write_ready_o,
  output mem_engine_pkg::word_t      data_read_o,
  output logic                       data_read_valid_o,
  output logic                       task_finished_o
);

  import mem_engine_pkg::*;

  task_state_e state_q;
  task_state_e state_d;

  // controller can take a new command
  logic  open_q;
  // legal command strobe accepted this cycle
  logic  accept;
  // active beat states
  logic  in_write;
  logic  in_read;
  // latched command type of the current task
  logic  rd_task_q;
  // RAM output in the next cycle belongs to a read
  logic  rd_pend_q;
  word_t rdata_q;

  assign open_q   = (state_q == IDLE) || (state_q == DONE);
  assign accept   = open_q &&
                    ((task_i.cmd == `MEM_CMD_WRITE) || (task_i.cmd == `MEM_CMD_READ));
  assign in_write = (state_q == WRITE);
  assign in_read  = (state_q == READ);

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE, DONE:
      begin
        // DONE also takes a command so tasks run back to back
        if (accept)
        begin
          state_d = (task_i.cmd == `MEM_CMD_WRITE) ? WRITE : READ;
        end
        else
        begin
          state_d = IDLE;
        end
      end
      WRITE:
      begin
        if (ctr_last_i)
        begin
          state_d = DONE;
        end
      end
      READ:
      begin
        if (ctr_last_i)
        begin
          state_d = DRAIN;
        end
      end
      // final RAM word still in flight
      DRAIN:   state_d = DONE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_q           <= IDLE;
      rd_task_q         <= 1'b0;
      rd_pend_q         <= 1'b0;
      data_read_valid_o <= 1'b0;
      task_finished_o   <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      if (accept)
      begin
        rd_task_q <= (task_i.cmd == `MEM_CMD_READ);
      end
      // address issued now, word comes back next cycle
      rd_pend_q         <= in_read;
      data_read_valid_o <= rd_pend_q;
      // write ends on its last beat, read ends after its last valid word
      task_finished_o   <= (in_write && ctr_last_i) || ((state_q == DONE) && rd_task_q);
    end
  end

  // read data stage aligned with the valid bit
  always_ff @(posedge clk_i)
  begin
    if (rd_pend_q)
    begin
      rdata_q <= ram_rdata_i;
    end
  end

  assign data_read_o = rdata_q;

  // counter loads at the accepting edge and steps until the last address
  assign range_ctl_o.load  = accept;
  assign range_ctl_o.step  = (in_write || in_read) && !ctr_last_i;
  assign range_ctl_o.start = task_i.start_addr;

  // RAM port follows the counter
  assign ram_req_o.we    = in_write;
  assign ram_req_o.addr  = ctr_addr_i;
  assign ram_req_o.wdata = data_write_i;

  assign data_write_ready_o = in_write;

  a_legal_cmd: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    open_q |-> (task_i.cmd inside {`MEM_CMD_IDLE, `MEM_CMD_WRITE, `MEM_CMD_READ})
  ) else $error("illegal command code %0d", task_i.cmd);

  a_range_order: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    accept |-> (task_i.start_addr <= task_i.end_addr)
  ) else $error("start address above end address");

  // write beats follow an accepted write command and stop at the last address
  a_we_in_write: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    ram_req_o.we |->
      ($past(accept && (task_i.cmd == `MEM_CMD_WRITE)) || $past(ram_req_o.we && !ctr_last_i))
  ) else $error("RAM write enable outside a write task");

endmodule

// File: src/block_ram.sv
`timescale 1ns/1ps

`include "mem_engine_consts.svh"

module block_ram (
  input  logic                     clk_i,
  input  mem_engine_pkg::ram_req_t req_i,
  output mem_engine_pkg::word_t    rdata_o
);

  import mem_engine_pkg::*;

  // one storage word per address
  word_t mem_q [`MEM_DEPTH];

  // registered read port
  word_t rdata_q;

  always_ff @(posedge clk_i)
  begin
    if (req_i.we)
    begin
      mem_q[req_i.addr] <= req_i.wdata;
      // write-first so the new word shows on the read port
      rdata_q <= req_i.wdata;
    end
    else
    begin
      rdata_q <= mem_q[req_i.addr];
    end
  end

  // word appears one cycle after its address
  assign rdata_o = rdata_q;

endmodule

// File: src/range_counter.sv
`timescale 1ns/1ps

module range_counter (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  mem_engine_pkg::range_ctl_t ctl_i,
  input  mem_engine_pkg::addr_t      end_addr_i,
  output mem_engine_pkg::addr_t      count_o,
  output logic                       last_o
);

  import mem_engine_pkg::*;

  // current address of the walk
  addr_t count_q;
  // end address captured at load
  addr_t end_q;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      count_q <= '0;
      end_q   <= '0;
    end
    else if (ctl_i.load)
    begin
      // load wins over step
      count_q <= ctl_i.start;
      end_q   <= end_addr_i;
    end
    else if (ctl_i.step && (count_q != end_q))
    begin
      // ascending only, saturates at the end address
      count_q <= count_q + addr_t'(1);
    end
  end

  assign count_o = count_q;

  // last word of the range
  assign last_o = (count_q == end_q);

  // controller must stop stepping once the end is reached
  a_no_step_at_last: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (ctl_i.step && !ctl_i.load) |-> !last_o
  ) else $error("range_counter stepped while last_o was high");

endmodule

// File: src/mem_engine_pkg.sv
`include "mem_engine_consts.svh"

package mem_engine_pkg;

  // widths with a meaning of their own
  typedef logic [`MEM_ADDR_W-1:0] addr_t;
  typedef logic [`MEM_DATA_W-1:0] word_t;
  typedef logic [1:0]             cmd_t;

  // client request, start and end are inclusive
  typedef struct packed {
    cmd_t  cmd;
    addr_t start_addr;
    addr_t end_addr;
  } mem_task_t;

  // single-port RAM request
  typedef struct packed {
    logic  we;
    addr_t addr;
    word_t wdata;
  } ram_req_t;

  // range counter control
  typedef struct packed {
    logic  load;
    logic  step;
    addr_t start;
  } range_ctl_t;

  // task controller states
  typedef enum logic [2:0] {
    IDLE,
    WRITE,
    READ,
    DRAIN,
    DONE
  } task_state_e;

endpackage

// File: src/mem_engine_consts.svh
`ifndef MEM_ENGINE_CONSTS_SVH
`define MEM_ENGINE_CONSTS_SVH

// word address and data word widths
`define MEM_ADDR_W 16
`define MEM_DATA_W 16

// RAM size in words over the full 16-bit address decode
`define MEM_DEPTH 65536

// client command codes
// code 3 is illegal
`define MEM_CMD_IDLE  2'd0
`define MEM_CMD_WRITE 2'd1
`define MEM_CMD_READ  2'd2

`endif
